// ==== mipsIsaPkg.sv ====
`default_nettype none

package mipsIsaPkg;

	// word and register-number widths
	localparam int wordW = 32;
	localparam int regAddrW = 5;

	// first fetch address out of reset
	localparam logic [wordW-1:0] resetPc = '0;

	////////////////////
	// instruction field layout
	localparam int opW = 6;
	localparam int opLsb = 26;
	localparam int rsLsb = 21;
	localparam int rtLsb = 16;
	localparam int rdLsb = 11;
	localparam int functLsb = 0;
	localparam int immW = 16;
	localparam int targetW = 26;

	// primary opcodes
	// codes not listed here decode as nop
	typedef enum logic [opW-1:0] {
		special = 6'h00,
		j = 6'h02,
		beq = 6'h04,
		bne = 6'h05,
		addiu = 6'h09,
		ori = 6'h0d,
		lui = 6'h0f,
		lb = 6'h20,
		lw = 6'h23,
		lbu = 6'h24,
		sb = 6'h28,
		sw = 6'h2b
	} opcodeT;

	// funct field of special
	typedef enum logic [opW-1:0] {
		mfhi = 6'h10,
		mthi = 6'h11,
		mflo = 6'h12,
		mtlo = 6'h13,
		addu = 6'h21,
		subu = 6'h23,
		andF = 6'h24,
		orF = 6'h25,
		slt = 6'h2a
	} functT;

endpackage

`default_nettype wire

// ==== coreCtrlPkg.sv ====
`default_nettype none

package coreCtrlPkg;

	// alu operation select
	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluSlt,
		aluLui
	} aluOpT;

	// writeback source
	typedef enum logic [1:0] {
		resAlu,
		resMem,
		resHi,
		resLo
	} resultSelT;

	// access kind for loads and stores
	typedef enum logic [1:0] {
		sizeWord,
		sizeByteS,
		sizeByteU
	} memSizeT;

	////////////////////
	// local memory geometry, per half
	localparam int memWords = 1024;
	localparam int memAddrW = $clog2(memWords);

endpackage

`default_nettype wire

// ==== controlDecoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module controlDecoder (
	input mipsIsaPkg::opcodeT op,
	input mipsIsaPkg::functT funct,
	output logic regWrite,
	output logic regDst,
	output logic aluSrc,
	output logic zeroExt,
	output coreCtrlPkg::aluOpT aluOp,
	output coreCtrlPkg::resultSelT resultSel,
	output logic memWrite,
	output coreCtrlPkg::memSizeT memSize,
	output logic branchEq,
	output logic branchNe,
	output logic jump,
	output logic hiWrite,
	output logic loWrite
);

	always_comb begin
		// defaults describe a nop
		regWrite = 1'b0;
		regDst = 1'b0;
		aluSrc = 1'b0;
		zeroExt = 1'b0;
		aluOp = coreCtrlPkg::aluAdd;
		resultSel = coreCtrlPkg::resAlu;
		memWrite = 1'b0;
		memSize = coreCtrlPkg::sizeWord;
		branchEq = 1'b0;
		branchNe = 1'b0;
		jump = 1'b0;
		hiWrite = 1'b0;
		loWrite = 1'b0;
		case (op)
			mipsIsaPkg::special: begin
				// register forms target rd
				regDst = 1'b1;
				case (funct)
					mipsIsaPkg::addu: regWrite = 1'b1;
					mipsIsaPkg::subu: begin
						regWrite = 1'b1;
						aluOp = coreCtrlPkg::aluSub;
					end
					mipsIsaPkg::andF: begin
						regWrite = 1'b1;
						aluOp = coreCtrlPkg::aluAnd;
					end
					mipsIsaPkg::orF: begin
						regWrite = 1'b1;
						aluOp = coreCtrlPkg::aluOr;
					end
					mipsIsaPkg::slt: begin
						regWrite = 1'b1;
						aluOp = coreCtrlPkg::aluSlt;
					end
					mipsIsaPkg::mfhi: begin
						regWrite = 1'b1;
						resultSel = coreCtrlPkg::resHi;
					end
					mipsIsaPkg::mflo: begin
						regWrite = 1'b1;
						resultSel = coreCtrlPkg::resLo;
					end
					// moves to hi/lo take rs only
					mipsIsaPkg::mthi: hiWrite = 1'b1;
					mipsIsaPkg::mtlo: loWrite = 1'b1;
					default: regDst = 1'b0;
				endcase
			end
			mipsIsaPkg::addiu: begin
				regWrite = 1'b1;
				aluSrc = 1'b1;
			end
			mipsIsaPkg::ori: begin
				regWrite = 1'b1;
				aluSrc = 1'b1;
				zeroExt = 1'b1;
				aluOp = coreCtrlPkg::aluOr;
			end
			mipsIsaPkg::lui: begin
				regWrite = 1'b1;
				aluSrc = 1'b1;
				aluOp = coreCtrlPkg::aluLui;
			end
			// address is rs plus signed offset
			mipsIsaPkg::lw, mipsIsaPkg::lb, mipsIsaPkg::lbu: begin
				regWrite = 1'b1;
				aluSrc = 1'b1;
				resultSel = coreCtrlPkg::resMem;
				if (op == mipsIsaPkg::lb)
					memSize = coreCtrlPkg::sizeByteS;
				else if (op == mipsIsaPkg::lbu)
					memSize = coreCtrlPkg::sizeByteU;
			end
			mipsIsaPkg::sw, mipsIsaPkg::sb: begin
				memWrite = 1'b1;
				aluSrc = 1'b1;
				if (op == mipsIsaPkg::sb)
					memSize = coreCtrlPkg::sizeByteU;
			end
			mipsIsaPkg::beq: branchEq = 1'b1;
			mipsIsaPkg::bne: branchNe = 1'b1;
			mipsIsaPkg::j: jump = 1'b1;
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// ==== hazardUnit.sv ====
`timescale 1ns/10ps
`default_nettype none

module hazardUnit (
	input logic [mipsIsaPkg::regAddrW-1:0] rsD,
	input logic [mipsIsaPkg::regAddrW-1:0] rtD,
	input logic [mipsIsaPkg::regAddrW-1:0] rsE,
	input logic [mipsIsaPkg::regAddrW-1:0] rtE,
	input logic [mipsIsaPkg::regAddrW-1:0] writeRegE,
	input logic [mipsIsaPkg::regAddrW-1:0] writeRegM,
	input logic [mipsIsaPkg::regAddrW-1:0] writeRegW,
	input logic regWriteE,
	input logic regWriteM,
	input logic regWriteW,
	input logic memToRegE,
	input logic memToRegM,
	input logic branchD,
	output logic forwardAD,
	output logic forwardBD,
	output logic [1:0] forwardAE,
	output logic [1:0] forwardBE,
	output logic stallF,
	output logic stallD,
	output logic flushE
);

	logic lwStall;
	logic branchStall;

	// execute operands
	// 2'b10 takes memory stage, 2'b01 takes writeback, memory wins
	assign forwardAE = (rsE != '0 && regWriteM && rsE == writeRegM) ? 2'b10 :
		(rsE != '0 && regWriteW && rsE == writeRegW) ? 2'b01 : 2'b00;
	assign forwardBE = (rtE != '0 && regWriteM && rtE == writeRegM) ? 2'b10 :
		(rtE != '0 && regWriteW && rtE == writeRegW) ? 2'b01 : 2'b00;

	// branch compare in decode only sees the memory stage
	// writeback is covered by the regfile bypass
	assign forwardAD = rsD != '0 && regWriteM && rsD == writeRegM;
	assign forwardBD = rtD != '0 && regWriteM && rtD == writeRegM;

	// load result not ready until writeback
	assign lwStall = memToRegE && (writeRegE == rsD || writeRegE == rtD);

	// branch operand still in execute, or a load sitting in memory
	assign branchStall = branchD &&
		((regWriteE && (writeRegE == rsD || writeRegE == rtD)) ||
		(memToRegM && (writeRegM == rsD || writeRegM == rtD)));

	// freeze fetch/decode and drop a bubble into execute
	assign stallF = lwStall | branchStall;
	assign stallD = lwStall | branchStall;
	assign flushE = lwStall | branchStall;

endmodule

`default_nettype wire

// ==== regFile.sv ====
`timescale 1ns/10ps
`default_nettype none

module regFile (
	input logic clk,
	input logic we,
	input logic [mipsIsaPkg::regAddrW-1:0] ra1,
	input logic [mipsIsaPkg::regAddrW-1:0] ra2,
	input logic [mipsIsaPkg::regAddrW-1:0] wa,
	input logic [mipsIsaPkg::wordW-1:0] wd,
	output logic [mipsIsaPkg::wordW-1:0] rd1,
	output logic [mipsIsaPkg::wordW-1:0] rd2
);

	logic [mipsIsaPkg::wordW-1:0] regs [2**mipsIsaPkg::regAddrW];

	// r0 may be written, it just never reads back
	always_ff @(posedge clk) begin
		if (we)
			regs[wa] <= wd;
	end

	// same-cycle write passes through to decode
	assign rd1 = (ra1 == '0) ? '0 : (we && wa == ra1) ? wd : regs[ra1];
	assign rd2 = (ra2 == '0) ? '0 : (we && wa == ra2) ? wd : regs[ra2];

endmodule

`default_nettype wire

// ==== alu.sv ====
`timescale 1ns/10ps
`default_nettype none

module alu (
	input logic [mipsIsaPkg::wordW-1:0] a,
	input logic [mipsIsaPkg::wordW-1:0] b,
	input coreCtrlPkg::aluOpT op,
	output logic [mipsIsaPkg::wordW-1:0] y
);

	logic lessThan;

	// signed compare for slt
	assign lessThan = $signed(a) < $signed(b);

	always_comb begin
		case (op)
			// add/sub wrap, no overflow trap
			coreCtrlPkg::aluAdd: y = a + b;
			coreCtrlPkg::aluSub: y = a - b;
			coreCtrlPkg::aluAnd: y = a & b;
			coreCtrlPkg::aluOr: y = a | b;
			coreCtrlPkg::aluSlt: y = {{(mipsIsaPkg::wordW-1){1'b0}}, lessThan};
			// immediate into the upper half
			coreCtrlPkg::aluLui: y = b << mipsIsaPkg::immW;
			default: y = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== memAlign.sv ====
`timescale 1ns/10ps
`default_nettype none

module memAlign (
	input coreCtrlPkg::memSizeT sizeM,
	input logic storeM,
	input logic [mipsIsaPkg::wordW-1:0] addrM,
	input logic [mipsIsaPkg::wordW-1:0] storeDataM,
	output logic [3:0] byteEn,
	output logic [mipsIsaPkg::wordW-1:0] writeData,
	input coreCtrlPkg::memSizeT sizeW,
	input logic [1:0] addrLowW,
	input logic [mipsIsaPkg::wordW-1:0] readWordW,
	output logic [mipsIsaPkg::wordW-1:0] loadData
);

	logic [7:0] loadByte;

	////////////////////
	// store side
	// byte goes out on every lane, enable picks the one
	assign writeData = (sizeM == coreCtrlPkg::sizeWord) ? storeDataM : {4{storeDataM[7:0]}};

	always_comb begin
		if (!storeM)
			byteEn = 4'b0000;
		else if (sizeM == coreCtrlPkg::sizeWord)
			byteEn = 4'b1111;
		else
			byteEn = 4'b0001 << addrM[1:0];
	end

	////////////////////
	// load side
	// little endian, lane 0 at address offset 0
	assign loadByte = readWordW[8*addrLowW +: 8];

	always_comb begin
		case (sizeW)
			coreCtrlPkg::sizeByteS: loadData = {{(mipsIsaPkg::wordW-8){loadByte[7]}}, loadByte};
			coreCtrlPkg::sizeByteU: loadData = {{(mipsIsaPkg::wordW-8){1'b0}}, loadByte};
			default: loadData = readWordW;
		endcase
	end

endmodule

`default_nettype wire

// ==== datapath.sv ====
`timescale 1ns/10ps
`default_nettype none

module datapath (
	input logic clk,
	input logic rst,
	output logic [mipsIsaPkg::wordW-1:0] pcF,
	input logic [mipsIsaPkg::wordW-1:0] instrF,
	output logic [mipsIsaPkg::wordW-1:0] dataAddrM,
	output logic [mipsIsaPkg::wordW-1:0] writeDataM,
	output logic [3:0] byteEnM,
	input logic [mipsIsaPkg::wordW-1:0] readDataM,
	output logic wbValid,
	output logic [mipsIsaPkg::wordW-1:0] wbPc,
	output logic [mipsIsaPkg::regAddrW-1:0] wbReg,
	output logic [mipsIsaPkg::wordW-1:0] wbData
);

	// fetch/decode
	logic [mipsIsaPkg::wordW-1:0] pcPlus4F, pcNextF, instrD, pcD, pcPlus4D;
	logic [mipsIsaPkg::wordW-1:0] immD, rd1D, rd2D, srcAD, srcBD, branchTargetD, jumpTargetD;
	logic [mipsIsaPkg::regAddrW-1:0] rsD, rtD, rdD, writeRegD;
	logic regWriteD, regDstD, aluSrcD, zeroExtD, memWriteD, branchEqD, branchNeD;
	logic jumpD, hiWriteD, loWriteD, branchD, pcSrcD;
	coreCtrlPkg::aluOpT aluOpD;
	coreCtrlPkg::resultSelT resultSelD;
	coreCtrlPkg::memSizeT memSizeD;
	// hazard controls
	logic forwardAD, forwardBD, stallF, stallD, flushE;
	logic [1:0] forwardAE, forwardBE;
	// execute
	logic [mipsIsaPkg::wordW-1:0] pcE, srcAE, srcBE, immE, srcAFwdE, srcBFwdE;
	logic [mipsIsaPkg::wordW-1:0] aluBE, aluYE, hiE, loE, exResultE;
	logic [mipsIsaPkg::regAddrW-1:0] rsE, rtE, writeRegE;
	logic regWriteE, aluSrcE, memWriteE, hiWriteE, loWriteE, memToRegE;
	coreCtrlPkg::aluOpT aluOpE;
	coreCtrlPkg::resultSelT resultSelE;
	coreCtrlPkg::memSizeT memSizeE;
	// memory
	logic [mipsIsaPkg::wordW-1:0] pcM, aluOutM, srcAM, storeDataM, hiReg, loReg;
	logic [mipsIsaPkg::regAddrW-1:0] writeRegM;
	logic regWriteM, memToRegM, memWriteM, hiWriteM, loWriteM;
	coreCtrlPkg::memSizeT memSizeM;
	// writeback
	logic [mipsIsaPkg::wordW-1:0] pcW, aluOutW, readDataW, loadDataW, resultW;
	logic [mipsIsaPkg::regAddrW-1:0] writeRegW;
	logic regWriteW, memToRegW;
	coreCtrlPkg::memSizeT memSizeW;

	////////////////////
	// fetch
	assign pcPlus4F = pcF + 4;
	// jump beats branch beats sequential
	assign pcNextF = jumpD ? jumpTargetD : (pcSrcD ? branchTargetD : pcPlus4F);

	always_ff @(posedge clk) begin
		if (rst)
			pcF <= mipsIsaPkg::resetPc;
		else if (!stallF)
			pcF <= pcNextF;
	end

	// no decode flush, the slot always runs
	always_ff @(posedge clk) begin
		if (rst) begin
			instrD <= '0;
			pcD <= mipsIsaPkg::resetPc;
		end else if (!stallD) begin
			instrD <= instrF;
			pcD <= pcF;
		end
	end

	////////////////////
	// decode
	assign rsD = instrD[mipsIsaPkg::rsLsb +: mipsIsaPkg::regAddrW];
	assign rtD = instrD[mipsIsaPkg::rtLsb +: mipsIsaPkg::regAddrW];
	assign rdD = instrD[mipsIsaPkg::rdLsb +: mipsIsaPkg::regAddrW];
	assign writeRegD = regDstD ? rdD : rtD;
	assign immD = zeroExtD ?
		{{(mipsIsaPkg::wordW-mipsIsaPkg::immW){1'b0}}, instrD[mipsIsaPkg::immW-1:0]} :
		{{(mipsIsaPkg::wordW-mipsIsaPkg::immW){instrD[mipsIsaPkg::immW-1]}},
		instrD[mipsIsaPkg::immW-1:0]};

	controlDecoder decoder (
		.op(mipsIsaPkg::opcodeT'(instrD[mipsIsaPkg::opLsb +: mipsIsaPkg::opW])),
		.funct(mipsIsaPkg::functT'(instrD[mipsIsaPkg::functLsb +: mipsIsaPkg::opW])),
		.regWrite(regWriteD), .regDst(regDstD), .aluSrc(aluSrcD), .zeroExt(zeroExtD),
		.aluOp(aluOpD), .resultSel(resultSelD), .memWrite(memWriteD), .memSize(memSizeD),
		.branchEq(branchEqD), .branchNe(branchNeD), .jump(jumpD),
		.hiWrite(hiWriteD), .loWrite(loWriteD)
	);

	regFile regs (
		.clk(clk), .we(regWriteW), .ra1(rsD), .ra2(rtD), .wa(writeRegW), .wd(resultW),
		.rd1(rd1D), .rd2(rd2D)
	);

	// delay-slot pc is the base for both targets
	assign pcPlus4D = pcD + 4;
	assign branchTargetD = pcPlus4D + {immD[mipsIsaPkg::wordW-3:0], 2'b00};
	assign jumpTargetD = {pcPlus4D[mipsIsaPkg::wordW-1:mipsIsaPkg::targetW+2],
		instrD[mipsIsaPkg::targetW-1:0], 2'b00};

	// compare with the memory-stage result forwarded
	assign srcAD = forwardAD ? aluOutM : rd1D;
	assign srcBD = forwardBD ? aluOutM : rd2D;
	assign branchD = branchEqD | branchNeD;
	assign pcSrcD = (branchEqD && srcAD == srcBD) || (branchNeD && srcAD != srcBD);

	hazardUnit hazards (
		.rsD(rsD), .rtD(rtD), .rsE(rsE), .rtE(rtE),
		.writeRegE(writeRegE), .writeRegM(writeRegM), .writeRegW(writeRegW),
		.regWriteE(regWriteE), .regWriteM(regWriteM), .regWriteW(regWriteW),
		.memToRegE(memToRegE), .memToRegM(memToRegM), .branchD(branchD),
		.forwardAD(forwardAD), .forwardBD(forwardBD),
		.forwardAE(forwardAE), .forwardBE(forwardBE),
		.stallF(stallF), .stallD(stallD), .flushE(flushE)
	);

	// stall bubble clears control, operands ride along
	always_ff @(posedge clk) begin
		if (rst || flushE) begin
			regWriteE <= 1'b0;
			aluSrcE <= 1'b0;
			aluOpE <= coreCtrlPkg::aluAdd;
			resultSelE <= coreCtrlPkg::resAlu;
			memWriteE <= 1'b0;
			memSizeE <= coreCtrlPkg::sizeWord;
			hiWriteE <= 1'b0;
			loWriteE <= 1'b0;
		end else begin
			regWriteE <= regWriteD;
			aluSrcE <= aluSrcD;
			aluOpE <= aluOpD;
			resultSelE <= resultSelD;
			memWriteE <= memWriteD;
			memSizeE <= memSizeD;
			hiWriteE <= hiWriteD;
			loWriteE <= loWriteD;
		end
		pcE <= pcD;
		srcAE <= rd1D;
		srcBE <= rd2D;
		immE <= immD;
		rsE <= rsD;
		rtE <= rtD;
		writeRegE <= writeRegD;
	end

	////////////////////
	// execute
	assign srcAFwdE = forwardAE[1] ? aluOutM : (forwardAE[0] ? resultW : srcAE);
	assign srcBFwdE = forwardBE[1] ? aluOutM : (forwardBE[0] ? resultW : srcBE);
	assign aluBE = aluSrcE ? immE : srcBFwdE;
	assign memToRegE = resultSelE == coreCtrlPkg::resMem;

	alu execAlu (
		.a(srcAFwdE), .b(aluBE), .op(aluOpE), .y(aluYE)
	);

	// mthi/mtlo still in memory beats the stored copy
	assign hiE = hiWriteM ? srcAM : hiReg;
	assign loE = loWriteM ? srcAM : loReg;

	// mfhi/mflo resolve here so memory can forward them
	always_comb begin
		case (resultSelE)
			coreCtrlPkg::resHi: exResultE = hiE;
			coreCtrlPkg::resLo: exResultE = loE;
			default: exResultE = aluYE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			regWriteM <= 1'b0;
			memToRegM <= 1'b0;
			memWriteM <= 1'b0;
			memSizeM <= coreCtrlPkg::sizeWord;
			hiWriteM <= 1'b0;
			loWriteM <= 1'b0;
		end else begin
			regWriteM <= regWriteE;
			memToRegM <= memToRegE;
			memWriteM <= memWriteE;
			memSizeM <= memSizeE;
			hiWriteM <= hiWriteE;
			loWriteM <= loWriteE;
		end
		pcM <= pcE;
		aluOutM <= exResultE;
		srcAM <= srcAFwdE;
		storeDataM <= srcBFwdE;
		writeRegM <= writeRegE;
	end

	////////////////////
	// memory
	assign dataAddrM = aluOutM;

	// hi/lo take rs as the move leaves memory
	always_ff @(posedge clk) begin
		if (hiWriteM)
			hiReg <= srcAM;
		if (loWriteM)
			loReg <= srcAM;
	end

	memAlign align (
		.sizeM(memSizeM), .storeM(memWriteM), .addrM(aluOutM), .storeDataM(storeDataM),
		.byteEn(byteEnM), .writeData(writeDataM),
		.sizeW(memSizeW), .addrLowW(aluOutW[1:0]), .readWordW(readDataW),
		.loadData(loadDataW)
	);

	always_ff @(posedge clk) begin
		if (rst) begin
			regWriteW <= 1'b0;
			memToRegW <= 1'b0;
			memSizeW <= coreCtrlPkg::sizeWord;
		end else begin
			regWriteW <= regWriteM;
			memToRegW <= memToRegM;
			memSizeW <= memSizeM;
		end
		pcW <= pcM;
		aluOutW <= aluOutM;
		readDataW <= readDataM;
		writeRegW <= writeRegM;
	end

	////////////////////
	// writeback and trace
	assign resultW = memToRegW ? loadDataW : aluOutW;
	// r0 writes show up too
	assign wbValid = regWriteW;
	assign wbPc = pcW;
	assign wbReg = writeRegW;
	assign wbData = resultW;

endmodule

`default_nettype wire

// ==== localMem.sv ====
`timescale 1ns/10ps
`default_nettype none

module localMem (
	input logic clk,
	input logic rst,
	input logic loadStrobe,
	input logic [coreCtrlPkg::memAddrW-1:0] loadAddr,
	input logic [mipsIsaPkg::wordW-1:0] loadData,
	input logic [mipsIsaPkg::wordW-1:0] pcF,
	output logic [mipsIsaPkg::wordW-1:0] instrF,
	input logic [mipsIsaPkg::wordW-1:0] dataAddr,
	input logic [3:0] byteEn,
	input logic [mipsIsaPkg::wordW-1:0] writeData,
	output logic [mipsIsaPkg::wordW-1:0] readData
);

	logic [mipsIsaPkg::wordW-1:0] instrMem [coreCtrlPkg::memWords];
	logic [mipsIsaPkg::wordW-1:0] dataMem [coreCtrlPkg::memWords];
	logic [coreCtrlPkg::memAddrW-1:0] instrIdx;
	logic [coreCtrlPkg::memAddrW-1:0] dataIdx;

	// byte addresses to word index, upper bits wrap
	assign instrIdx = pcF[coreCtrlPkg::memAddrW+1:2];
	assign dataIdx = dataAddr[coreCtrlPkg::memAddrW+1:2];

	// program load
	// only accepted while the core sits in reset
	always_ff @(posedge clk) begin
		if (rst && loadStrobe)
			instrMem[loadAddr] <= loadData;
	end

	// per-byte data write
	always_ff @(posedge clk) begin
		for (int i = 0; i < 4; i++) begin
			if (byteEn[i])
				dataMem[dataIdx][8*i +: 8] <= writeData[8*i +: 8];
		end
	end

	// both ports read combinationally
	assign instrF = instrMem[instrIdx];
	assign readData = dataMem[dataIdx];

endmodule

`default_nettype wire

// ==== mipsCore.sv ====
`timescale 1ns/10ps
`default_nettype none

module mipsCore (
	input logic clk,
	input logic rst,
	input logic loadStrobe,
	input logic [coreCtrlPkg::memAddrW-1:0] loadAddr,
	input logic [mipsIsaPkg::wordW-1:0] loadData,
	output logic wbValid,
	output logic [mipsIsaPkg::wordW-1:0] wbPc,
	output logic [mipsIsaPkg::regAddrW-1:0] wbReg,
	output logic [mipsIsaPkg::wordW-1:0] wbData
);

	// fetch port
	logic [mipsIsaPkg::wordW-1:0] pcF;
	logic [mipsIsaPkg::wordW-1:0] instrF;
	// data port
	logic [mipsIsaPkg::wordW-1:0] dataAddrM;
	logic [mipsIsaPkg::wordW-1:0] writeDataM;
	logic [mipsIsaPkg::wordW-1:0] readDataM;
	logic [3:0] byteEnM;

	datapath core (
		.clk(clk), .rst(rst),
		.pcF(pcF), .instrF(instrF),
		.dataAddrM(dataAddrM), .writeDataM(writeDataM), .byteEnM(byteEnM),
		.readDataM(readDataM),
		.wbValid(wbValid), .wbPc(wbPc), .wbReg(wbReg), .wbData(wbData)
	);

	localMem mem (
		.clk(clk), .rst(rst),
		.loadStrobe(loadStrobe), .loadAddr(loadAddr), .loadData(loadData),
		.pcF(pcF), .instrF(instrF),
		.dataAddr(dataAddrM), .byteEn(byteEnM), .writeData(writeDataM),
		.readData(readDataM)
	);

endmodule

`default_nettype wire

// ==== tbMipsCore.sv ====
`timescale 1ns/10ps
`default_nettype none

module tbMipsCore;

	// vector capacity and wait limits, in clock cycles
	localparam int maxEntries = 256;
	localparam int waitCycles = 50;
	localparam int idleCycles = 20;

	logic clk;
	logic rst;
	logic loadStrobe;
	logic [coreCtrlPkg::memAddrW-1:0] loadAddr;
	logic [mipsIsaPkg::wordW-1:0] loadData;
	logic wbValid;
	logic [mipsIsaPkg::wordW-1:0] wbPc;
	logic [mipsIsaPkg::regAddrW-1:0] wbReg;
	logic [mipsIsaPkg::wordW-1:0] wbData;

	// program image and expected trace
	logic [mipsIsaPkg::wordW-1:0] progAddr [maxEntries];
	logic [mipsIsaPkg::wordW-1:0] progWord [maxEntries];
	logic [mipsIsaPkg::wordW-1:0] expPc [maxEntries];
	logic [mipsIsaPkg::regAddrW-1:0] expReg [maxEntries];
	logic [mipsIsaPkg::wordW-1:0] expData [maxEntries];
	int progCount;
	int traceCount;
	int passCount;
	int failCount;
	bit arrived;

	mipsCore dut (
		.clk(clk), .rst(rst),
		.loadStrobe(loadStrobe), .loadAddr(loadAddr), .loadData(loadData),
		.wbValid(wbValid), .wbPc(wbPc), .wbReg(wbReg), .wbData(wbData)
	);

	// 100 ns period
	initial clk = 1'b0;
	always #50 clk = ~clk;

	////////////////////
	// compare tasks
	task automatic checkPc(input int idx, input logic [mipsIsaPkg::wordW-1:0] expected,
		input logic [mipsIsaPkg::wordW-1:0] actual);
		if (actual !== expected) begin
			$display("mismatch at %0t ns: wbPc entry %0d expected %h actual %h",
				$time, idx, expected, actual);
			failCount++;
		end else begin
			$display("ok entry %0d wbPc %h", idx, actual);
			passCount++;
		end
	endtask

	task automatic checkReg(input int idx, input logic [mipsIsaPkg::regAddrW-1:0] expected,
		input logic [mipsIsaPkg::regAddrW-1:0] actual);
		if (actual !== expected) begin
			$display("mismatch at %0t ns: wbReg entry %0d expected %0d actual %0d",
				$time, idx, expected, actual);
			failCount++;
		end else begin
			$display("ok entry %0d wbReg %0d", idx, actual);
			passCount++;
		end
	endtask

	task automatic checkData(input int idx, input logic [mipsIsaPkg::wordW-1:0] expected,
		input logic [mipsIsaPkg::wordW-1:0] actual);
		if (actual !== expected) begin
			$display("mismatch at %0t ns: wbData entry %0d expected %h actual %h",
				$time, idx, expected, actual);
			failCount++;
		end else begin
			$display("ok entry %0d wbData %h", idx, actual);
			passCount++;
		end
	endtask

	////////////////////
	// vectors file
	// P lines fill the program, T lines the trace, # lines are skipped
	task automatic readVectors();
		int fd;
		int code;
		bit done;
		logic [7:0] tag;
		logic [8*160-1:0] skipLine;
		logic [mipsIsaPkg::wordW-1:0] f1;
		logic [mipsIsaPkg::wordW-1:0] f2;
		logic [mipsIsaPkg::wordW-1:0] f3;
		done = 1'b0;
		fd = $fopen("mipsVectors.txt", "r");
		if (fd == 0) begin
			$display("error: the vectors file mipsVectors.txt could not be opened");
			failCount++;
			done = 1'b1;
		end
		while (!done) begin
			code = $fscanf(fd, " %c", tag);
			if (code != 1) begin
				done = 1'b1;
			end else if (tag == "P" && progCount < maxEntries) begin
				code = $fscanf(fd, "%h %h", f1, f2);
				progAddr[progCount] = f1;
				progWord[progCount] = f2;
				progCount++;
			end else if (tag == "T" && traceCount < maxEntries) begin
				code = $fscanf(fd, "%h %h %h", f1, f2, f3);
				expPc[traceCount] = f1;
				expReg[traceCount] = f2[mipsIsaPkg::regAddrW-1:0];
				expData[traceCount] = f3;
				traceCount++;
			end else begin
				// comment or unknown tag, drop the rest of the line
				code = $fgets(skipLine, fd);
			end
		end
		if (fd != 0)
			$fclose(fd);
		$display("read %0d program words and %0d trace entries", progCount, traceCount);
	endtask

	// one word per cycle while reset is held, at least four reset cycles
	task automatic loadProgram();
		int edges;
		edges = 0;
		for (int i = 0; i < progCount; i++) begin
			@(posedge clk);
			loadStrobe <= 1'b1;
			loadAddr <= progAddr[i][coreCtrlPkg::memAddrW+1:2];
			loadData <= progWord[i];
			edges++;
		end
		// last word is written on this edge, rst still high
		@(posedge clk);
		loadStrobe <= 1'b0;
		edges++;
		while (edges < 4) begin
			@(posedge clk);
			edges++;
		end
		rst <= 1'b0;
	endtask

	////////////////////
	// trace checking
	// sampled on the falling edge, away from the register updates
	task automatic waitRetirement(input int idx, output bit seen);
		int cycles;
		seen = 1'b0;
		cycles = 0;
		while (!seen && cycles < waitCycles) begin
			@(negedge clk);
			if (wbValid === 1'b1)
				seen = 1'b1;
			else
				cycles++;
		end
		if (seen) begin
			checkPc(idx, expPc[idx], wbPc);
			checkReg(idx, expReg[idx], wbReg);
			checkData(idx, expData[idx], wbData);
		end else begin
			$display("timeout: retirement %0d with pc %h never arrived within %0d cycles",
				idx, expPc[idx], waitCycles);
			failCount++;
		end
	endtask

	// program ends in a self-jump, so the trace must go quiet
	task automatic watchIdle();
		int extra;
		extra = 0;
		for (int i = 0; i < idleCycles; i++) begin
			@(negedge clk);
			if (wbValid === 1'b1) begin
				$display("error at %0t ns: extra retirement pc %h reg %0d data %h",
					$time, wbPc, wbReg, wbData);
				extra++;
			end
		end
		if (extra == 0) begin
			$display("ok no retirements in %0d idle cycles", idleCycles);
			passCount++;
		end else begin
			failCount++;
		end
	endtask

	// nothing may retire while reset is held
	always @(negedge clk) begin
		if (rst === 1'b1 && wbValid === 1'b1) begin
			$display("error at %0t ns: a retirement was reported while reset was held", $time);
			failCount++;
		end
	end

	////////////////////
	// main sequence
	initial begin
		rst = 1'b1;
		loadStrobe = 1'b0;
		loadAddr = '0;
		loadData = '0;
		progCount = 0;
		traceCount = 0;
		passCount = 0;
		failCount = 0;
		arrived = 1'b1;
		readVectors();
		loadProgram();
		for (int i = 0; i < traceCount && arrived; i++)
			waitRetirement(i, arrived);
		if (arrived)
			watchIdle();
		$display("checks passed %0d, failed %0d", passCount, failCount);
		if (failCount == 0 && traceCount > 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== mipsVectors.txt ====
# P byteAddr instrWord, all hex, loaded into instruction storage
# T pc reg data, all hex, one line per expected retirement in order
# alu chain with forwarding
P 00 3C011234
P 04 34215678
P 08 2402FFFF
P 0C 00221821
P 10 00612023
P 14 00812824
P 18 00A23025
P 1C 00C5382A
P 20 00A6402A
# r0 write then read
P 24 24000055
P 28 00074821
# stores, loads at every byte offset, load-use
P 2C 240A0100
P 30 AD410000
P 34 240B0080
P 38 A14B0001
P 3C A1420003
P 40 8D4C0000
P 44 01806821
P 48 814E0000
P 4C 814F0001
P 50 81500002
P 54 81510003
P 58 91520000
P 5C 91530001
P 60 91540002
P 64 91550003
P 68 02B1B023
# branches and jump with delay slots
P 6C 24170005
P 70 16E00002
P 74 24180001
P 78 24190099
P 7C 10250002
P 80 24190002
P 84 24190077
P 88 10220005
P 8C 241A0003
P 90 275A0001
P 94 8D5B0000
P 98 136C0002
P 9C 241C0006
P A0 241C0066
P A4 0800002C
P A8 241D0007
P AC 241D0088
# hi/lo moves
P B0 00200011
P B4 00001810
P B8 02C00013
P BC 00002012
P C0 00832821
P C4 00003010
P C8 00003812
# self-jump with nop slot
P CC 08000033
P D0 00000000
T 00 01 12340000
T 04 01 12345678
T 08 02 FFFFFFFF
T 0C 03 12345677
T 10 04 FFFFFFFF
T 14 05 12345678
T 18 06 FFFFFFFF
T 1C 07 00000001
T 20 08 00000000
T 24 00 00000055
T 28 09 00000001
T 2C 0A 00000100
T 34 0B 00000080
T 40 0C FF348078
T 44 0D FF348078
T 48 0E 00000078
T 4C 0F FFFFFF80
T 50 10 00000034
T 54 11 FFFFFFFF
T 58 12 00000078
T 5C 13 00000080
T 60 14 00000034
T 64 15 000000FF
T 68 16 00000100
T 6C 17 00000005
T 74 18 00000001
T 80 19 00000002
T 8C 1A 00000003
T 90 1A 00000004
T 94 1B FF348078
T 9C 1C 00000006
T A8 1D 00000007
T B4 03 12345678
T BC 04 00000100
T C0 05 12345778
T C4 06 12345678
T C8 07 00000100

// ==== project.f ====
mipsIsaPkg.sv
coreCtrlPkg.sv
controlDecoder.sv
hazardUnit.sv
regFile.sv
alu.sv
memAlign.sv
datapath.sv
localMem.sv
mipsCore.sv
tbMipsCore.sv

// ==== runSim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/10ps -Wno-fatal \
	--top-module tbMipsCore -f project.f -o simMips

./obj_dir/simMips | tee sim.log

if grep -q "^Simulation PASSED$" sim.log; then
	echo "result: pass"
else
	echo "result: fail"
	exit 1
fi
